/* include/cu_defines.svh */
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// Instruction classes in opcode bits 7:5, class 7 is unused
`define CLS_SYS 3'd0
`define CLS_RST 3'd1
`define CLS_INC 3'd2
`define CLS_MOV 3'd3
`define CLS_LD  3'd4
`define CLS_ALU 3'd5
`define CLS_JMP 3'd6

// Sub-operation indices, opcode bits 3:0
`define SYS_NOP   4'd0
`define SYS_ENDOP 4'd1
`define RST_ALL   4'd15

`define ALU_IDX_ADD  4'd0
`define ALU_IDX_MUL1 4'd1
`define ALU_IDX_MUL2 4'd2
`define ALU_IDX_DIV  4'd3
`define ALU_IDX_MOD  4'd4

`define JMP_UNC 2'd0
`define JMP_Z1  2'd1
`define JMP_Z2  2'd2

// Datapath register bit positions in the enable vectors
`define REG_PC   4'd0
`define REG_IR   4'd1
`define REG_GSP  4'd2
`define REG_RP   4'd3
`define REG_CP   4'd4
`define REG_STP  4'd5
`define REG_CID  4'd6
`define REG_EOPC 4'd7
`define REG_MC   4'd8
`define REG_MV   4'd9
`define REG_WV   4'd10
`define REG_MULR 4'd11
`define REG_ADDR 4'd12
`define REG_AC   4'd13
`define NUM_REGS 14

`define ALU_NONE 3'd0
`define ALU_ADD  3'd1
`define ALU_MUL  3'd2
`define ALU_DIV  3'd3
`define ALU_MOD  3'd4

`define BS_AC     4'd0
`define BS_MEMOUT 4'd1
`define BS_ADDR   4'd2
`define BS_MULR   4'd3
`define BS_MV     4'd4
`define BS_WV     4'd5

`define MEM_IDLE  2'd0
`define MEM_IREAD 2'd1
`define MEM_READ  2'd2

`endif

/* design/cuPkg.sv */
`include "cu_defines.svh"

package cuPkg;

	// Instruction byte: class 7:5, reserved bit 4, index 3:0
	typedef logic [7:0] opcodeT;
	typedef logic [2:0] insClassT;
	typedef logic [3:0] regIdxT;

	// One bit per datapath register
	typedef logic [`NUM_REGS-1:0] regMaskT;

	typedef logic [2:0] aluOpT;
	typedef logic [3:0] busSelT;
	typedef logic [1:0] memCtrlT;

	typedef enum logic [3:0] {
		FETCH1,
		FETCH2,
		EXEC,
		MEMWAIT,
		MEMDONE,
		JMP1,
		JMP2,
		JMP3,
		JMPN1,
		JMPN2,
		HALT
	} seqStateT;

	typedef struct packed {
		insClassT insClass;
		regIdxT idx;
		logic illegal;
		logic condTaken;
		logic [1:0] jmpKind;
	} decodedInsT;

	// All zero is the idle word
	typedef struct packed {
		aluOpT aluOp;
		busSelT busSel;
		memCtrlT memCtrl;
		regMaskT wrtEn;
		regMaskT incEn;
		regMaskT rstEn;
	} ctrlWordT;

endpackage

/* design/insDecoder.sv */
`timescale 1ns/1ps
`include "cu_defines.svh"

module insDecoder (
	input logic clk,
	input logic rstN,
	input cuPkg::opcodeT ins,
	input logic insLoad,
	input logic z1,
	input logic z2,
	output cuPkg::decodedInsT dec
);
	import cuPkg::*;

	insClassT insClass;
	regIdxT idx;
	logic badIdx;
	logic taken;

	assign insClass = ins[7:5];
	assign idx = ins[3:0];

	// Legal index range depends on the class
	always_comb begin
		case (insClass)
			`CLS_SYS: badIdx = idx > `SYS_ENDOP;
			`CLS_RST: badIdx = (idx < 4'd2) || ((idx >= 4'(`NUM_REGS)) && (idx != `RST_ALL));
			`CLS_INC,
			`CLS_MOV: badIdx = (idx < 4'd2) || (idx >= 4'(`NUM_REGS));
			`CLS_LD: badIdx = !((idx == `REG_AC) || (idx == `REG_ADDR) || (idx == `REG_MULR));
			`CLS_ALU: badIdx = idx > `ALU_IDX_MOD;
			`CLS_JMP: badIdx = idx > 4'(`JMP_Z2);
			default: badIdx = 1'b1;
		endcase
	end

	// Flags sampled together with the opcode
	always_comb begin
		case (idx[1:0])
			`JMP_Z1: taken = z1;
			`JMP_Z2: taken = !z2;
			default: taken = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dec <= '0;
		end else if (insLoad) begin
			dec.insClass <= insClass;
			dec.idx <= idx;
			dec.illegal <= ins[4] || badIdx;
			dec.condTaken <= taken;
			dec.jmpKind <= idx[1:0];
		end
	end

endmodule

/* design/microSequencer.sv */
`timescale 1ns/1ps
`include "cu_defines.svh"

module microSequencer (
	input logic clk,
	input logic rstN,
	input logic acq,
	input cuPkg::decodedInsT dec,
	output logic insLoad,
	output cuPkg::seqStateT state
);
	import cuPkg::*;

	seqStateT nextState;
	logic jmpTaken;

	// Opcode is captured on the fetch acknowledge
	assign insLoad = (state == FETCH1) && acq;

	assign jmpTaken = (dec.jmpKind == `JMP_UNC) || dec.condTaken;

	always_comb begin
		nextState = state;
		case (state)
			FETCH1: begin
				if (acq) begin
					nextState = FETCH2;
				end
			end
			FETCH2: begin
				nextState = EXEC;
			end
			EXEC: begin
				if (dec.illegal) begin
					nextState = FETCH1;
				end else begin
					case (dec.insClass)
						`CLS_SYS: begin
							if (dec.idx == `SYS_ENDOP) begin
								nextState = HALT;
							end else begin
								nextState = FETCH1;
							end
						end
						`CLS_LD: begin
							nextState = MEMWAIT;
						end
						`CLS_JMP: begin
							if (jmpTaken) begin
								nextState = JMP1;
							end else begin
								nextState = JMPN1;
							end
						end
						default: begin
							nextState = FETCH1;
						end
					endcase
				end
			end
			MEMWAIT: begin
				if (acq) begin
					nextState = MEMDONE;
				end
			end
			MEMDONE: begin
				nextState = FETCH1;
			end
			JMP1: begin
				nextState = JMP2;
			end
			JMP2: begin
				nextState = JMP3;
			end
			JMP3: begin
				nextState = FETCH1;
			end
			JMPN1: begin
				nextState = JMPN2;
			end
			JMPN2: begin
				nextState = FETCH1;
			end
			// Stuck here until reset
			HALT: begin
				nextState = HALT;
			end
			default: begin
				nextState = FETCH1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= FETCH1;
		end else begin
			state <= nextState;
		end
	end

endmodule

/* design/controlWordGen.sv */
`timescale 1ns/1ps
`include "cu_defines.svh"

module controlWordGen (
	input logic clk,
	input logic rstN,
	input cuPkg::seqStateT state,
	input cuPkg::decodedInsT dec,
	output cuPkg::ctrlWordT ctrl
);
	import cuPkg::*;

	ctrlWordT word;

	function automatic regMaskT regBit(input regIdxT idx);
		return regMaskT'(1) << idx;
	endfunction

	always_comb begin
		word = '0;
		case (state)
			FETCH1: begin
				word.memCtrl = `MEM_IREAD;
			end
			FETCH2: begin
				word.incEn = regBit(`REG_PC);
				word.wrtEn = regBit(`REG_IR);
			end
			EXEC: begin
				// Illegal opcodes give an idle word
				if (!dec.illegal) begin
					case (dec.insClass)
						`CLS_RST: begin
							if (dec.idx == `RST_ALL) begin
								word.rstEn = ~(regBit(`REG_PC) | regBit(`REG_IR));
							end else begin
								word.rstEn = regBit(dec.idx);
							end
						end
						`CLS_INC: begin
							word.incEn = regBit(dec.idx);
						end
						`CLS_MOV: begin
							word.busSel = `BS_AC;
							word.wrtEn = regBit(dec.idx);
						end
						`CLS_ALU: begin
							case (dec.idx)
								`ALU_IDX_ADD: begin
									word.aluOp = `ALU_ADD;
									word.busSel = `BS_ADDR;
								end
								`ALU_IDX_MUL1: begin
									word.aluOp = `ALU_MUL;
									word.busSel = `BS_MULR;
								end
								`ALU_IDX_MUL2: begin
									word.aluOp = `ALU_MUL;
									word.busSel = `BS_MV;
								end
								`ALU_IDX_DIV: begin
									word.aluOp = `ALU_DIV;
									word.busSel = `BS_WV;
								end
								`ALU_IDX_MOD: begin
									word.aluOp = `ALU_MOD;
									word.busSel = `BS_WV;
								end
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
			MEMWAIT: begin
				word.memCtrl = `MEM_READ;
			end
			// Load target is the register index
			MEMDONE: begin
				word.busSel = `BS_MEMOUT;
				word.wrtEn = regBit(dec.idx);
			end
			JMP1: begin
				word.wrtEn = regBit(`REG_IR);
			end
			JMP2: begin
				word.wrtEn = regBit(`REG_PC);
			end
			JMPN1: begin
				word.incEn = regBit(`REG_PC);
				word.wrtEn = regBit(`REG_IR);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrl <= '0;
		end else begin
			ctrl <= word;
		end
	end

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rstN,
	input cuPkg::opcodeT ins,
	input logic acq,
	input logic z1,
	input logic z2,
	output cuPkg::ctrlWordT ctrl
);
	import cuPkg::*;

	decodedInsT dec;
	seqStateT state;
	logic insLoad;

	insDecoder i_insDecoder (
		.clk(clk),
		.rstN(rstN),
		.ins(ins),
		.insLoad(insLoad),
		.z1(z1),
		.z2(z2),
		.dec(dec)
	);

	microSequencer i_microSequencer (
		.clk(clk),
		.rstN(rstN),
		.acq(acq),
		.dec(dec),
		.insLoad(insLoad),
		.state(state)
	);

	controlWordGen i_controlWordGen (
		.clk(clk),
		.rstN(rstN),
		.state(state),
		.dec(dec),
		.ctrl(ctrl)
	);

endmodule

/* verif/cu_props.sv */
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_props (
	input logic clk,
	input logic rstN,
	input cuPkg::ctrlWordT ctrl
);
	import cuPkg::*;

	// Failed assertions, read by the testbench at the end of the run
	int failCount = 0;

	// Reset enables never mix with write or increment
	rstExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!((|ctrl.rstEn) && ((|ctrl.wrtEn) || (|ctrl.incEn))))
		else begin
			$error("reset enable active together with write or increment enable");
			failCount++;
		end

	// ALU steps only drive the bus
	aluNoEnables: assert property (@(posedge clk) disable iff (!rstN)
		(ctrl.aluOp != `ALU_NONE) |-> ((ctrl.wrtEn == '0) && (ctrl.incEn == '0)
		&& (ctrl.rstEn == '0)))
		else begin
			$error("ALU operation issued together with register enables");
			failCount++;
		end

	idleAfterReset: assert property (@(posedge clk) !rstN |=> (ctrl == '0))
		else begin
			$error("control word not idle in the cycle after reset");
			failCount++;
		end

endmodule

bind controlUnit cu_props i_cuProps (
	.clk(clk),
	.rstN(rstN),
	.ctrl(ctrl)
);

/* verif/cu_tb.sv */
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_tb;
	import cuPkg::*;

	logic clk;
	logic rstN;
	opcodeT ins;
	logic acq;
	logic z1;
	logic z2;
	ctrlWordT ctrl;

	// One entry per stimulus line
	opcodeT stimOp[$];
	int stimDelay[$];
	logic stimZ1[$];
	logic stimZ2[$];

	integer seed;
	int errCount;
	int assertFails;
	int timeouts;
	int cycles;
	int cycleLimit;

	// Memory model state
	int nextLine;
	int waitCnt;
	logic holdoff;

	// Reference model state
	seqStateT refState;
	opcodeT refOp;
	logic refZ1;
	logic refZ2;
	ctrlWordT expWord;
	string expName;

	controlUnit i_controlUnit (
		.clk(clk),
		.rstN(rstN),
		.ins(ins),
		.acq(acq),
		.z1(z1),
		.z2(z2),
		.ctrl(ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkWord(input string name, input ctrlWordT expected,
		input ctrlWordT actual);
		if (actual !== expected) begin
			errCount++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic isIllegal(input opcodeT op);
		regIdxT idx;
		logic bad;
		idx = op[3:0];
		case (op[7:5])
			`CLS_SYS: bad = idx > `SYS_ENDOP;
			`CLS_RST: bad = (idx < 4'd2) || ((idx > `REG_AC) && (idx != `RST_ALL));
			`CLS_INC,
			`CLS_MOV: bad = (idx < 4'd2) || (idx > `REG_AC);
			`CLS_LD: bad = (idx != `REG_AC) && (idx != `REG_ADDR) && (idx != `REG_MULR);
			`CLS_ALU: bad = idx > `ALU_IDX_MOD;
			`CLS_JMP: bad = idx > 4'(`JMP_Z2);
			default: bad = 1'b1;
		endcase
		return bad || op[4];
	endfunction

	function automatic seqStateT stateAfterExec(input opcodeT op, input logic zf1,
		input logic zf2);
		seqStateT nxt;
		logic taken;
		nxt = FETCH1;
		if (op[1:0] == `JMP_Z1) begin
			taken = zf1;
		end else if (op[1:0] == `JMP_Z2) begin
			taken = !zf2;
		end else begin
			taken = 1'b1;
		end
		if (!isIllegal(op)) begin
			case (op[7:5])
				`CLS_SYS: nxt = (op[3:0] == `SYS_ENDOP) ? HALT : FETCH1;
				`CLS_LD: nxt = MEMWAIT;
				`CLS_JMP: nxt = taken ? JMP1 : JMPN1;
				default: nxt = FETCH1;
			endcase
		end
		return nxt;
	endfunction

	// Word the unit should issue for one step
	function automatic ctrlWordT refWord(input seqStateT st, input opcodeT op);
		ctrlWordT w;
		regIdxT idx;
		w = '0;
		idx = op[3:0];
		case (st)
			FETCH1: w.memCtrl = `MEM_IREAD;
			FETCH2: begin
				w.incEn[`REG_PC] = 1'b1;
				w.wrtEn[`REG_IR] = 1'b1;
			end
			EXEC: begin
				if (!isIllegal(op)) begin
					case (op[7:5])
						`CLS_RST: begin
							if (idx == `RST_ALL) begin
								w.rstEn = 14'h3ffc;
							end else begin
								w.rstEn[idx] = 1'b1;
							end
						end
						`CLS_INC: w.incEn[idx] = 1'b1;
						`CLS_MOV: begin
							w.busSel = `BS_AC;
							w.wrtEn[idx] = 1'b1;
						end
						`CLS_ALU: begin
							case (idx)
								`ALU_IDX_ADD: begin
									w.aluOp = `ALU_ADD;
									w.busSel = `BS_ADDR;
								end
								`ALU_IDX_MUL1: begin
									w.aluOp = `ALU_MUL;
									w.busSel = `BS_MULR;
								end
								`ALU_IDX_MUL2: begin
									w.aluOp = `ALU_MUL;
									w.busSel = `BS_MV;
								end
								`ALU_IDX_DIV: begin
									w.aluOp = `ALU_DIV;
									w.busSel = `BS_WV;
								end
								default: begin
									w.aluOp = `ALU_MOD;
									w.busSel = `BS_WV;
								end
							endcase
						end
						default: ;
					endcase
				end
			end
			MEMWAIT: w.memCtrl = `MEM_READ;
			MEMDONE: begin
				w.busSel = `BS_MEMOUT;
				w.wrtEn[idx] = 1'b1;
			end
			JMP1: w.wrtEn[`REG_IR] = 1'b1;
			JMP2: w.wrtEn[`REG_PC] = 1'b1;
			JMPN1: begin
				w.incEn[`REG_PC] = 1'b1;
				w.wrtEn[`REG_IR] = 1'b1;
			end
			default: ;
		endcase
		return w;
	endfunction

	// Answers requests seen on ctrl after the line's delay
	task automatic driveMemory();
		int dly;
		acq = 1'b0;
		ins = opcodeT'($random(seed));
		z1 = 1'($random(seed));
		z2 = 1'($random(seed));
		dly = -1;
		if ((ctrl.memCtrl == `MEM_IREAD) && (nextLine < stimOp.size())) begin
			dly = stimDelay[nextLine];
		end else if ((ctrl.memCtrl == `MEM_READ) && (nextLine > 0)) begin
			dly = stimDelay[nextLine - 1];
		end
		// ctrl still shows the request one cycle after acq
		if (holdoff) begin
			holdoff = 1'b0;
		end else if (dly >= 0) begin
			if (waitCnt < dly) begin
				waitCnt++;
			end else begin
				acq = 1'b1;
				holdoff = 1'b1;
				waitCnt = 0;
				if (ctrl.memCtrl == `MEM_IREAD) begin
					ins = stimOp[nextLine];
					z1 = stimZ1[nextLine];
					z2 = stimZ2[nextLine];
					nextLine++;
				end
			end
		end
	endtask

	task automatic stepModel();
		case (refState)
			FETCH1: begin
				if (acq) begin
					refOp = ins;
					refZ1 = z1;
					refZ2 = z2;
					refState = FETCH2;
				end
			end
			FETCH2: refState = EXEC;
			EXEC: refState = stateAfterExec(refOp, refZ1, refZ2);
			MEMWAIT: begin
				if (acq) begin
					refState = MEMDONE;
				end
			end
			JMP1: refState = JMP2;
			JMP2: refState = JMP3;
			JMPN1: refState = JMPN2;
			HALT: refState = HALT;
			default: refState = FETCH1;
		endcase
	endtask

	initial begin
		int fd;
		int nItems;
		string lineStr;
		opcodeT op;
		int dly;
		int zf1;
		int zf2;
		int haltCycles;
		bit done;

		rstN = 1'b0;
		ins = '0;
		acq = 1'b0;
		z1 = 1'b0;
		z2 = 1'b0;
		seed = 32'hc090;
		errCount = 0;
		assertFails = 0;
		timeouts = 0;
		cycles = 0;
		cycleLimit = 40;
		nextLine = 0;
		waitCnt = 0;
		holdoff = 1'b0;
		haltCycles = 0;

		fd = $fopen("verif/cu_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file verif/cu_stim.txt");
			errCount++;
		end else begin
			while ($fgets(lineStr, fd) != 0) begin
				if ((lineStr.len() > 1) && (lineStr.substr(0, 1) != "//")) begin
					nItems = $sscanf(lineStr, "%h %d %d %d", op, dly, zf1, zf2);
					if (nItems == 4) begin
						stimOp.push_back(op);
						stimDelay.push_back(dly);
						stimZ1.push_back(zf1 != 0);
						stimZ2.push_back(zf2 != 0);
						cycleLimit += dly + 8;
						// Loads wait on memory twice
						if (op[7:5] == `CLS_LD) begin
							cycleLimit += dly;
						end
					end
				end
			end
			$fclose(fd);
			if (stimOp.size() == 0) begin
				$display("The stimulus file holds no instructions");
				errCount++;
			end
		end

		for (int i = 0; (i < 10) && (errCount == 0); i++) begin
			@(negedge clk);
			checkWord("reset", '0, ctrl);
		end
		done = (errCount != 0);

		rstN = 1'b1;
		refState = FETCH1;
		refOp = '0;
		refZ1 = 1'b0;
		refZ2 = 1'b0;
		expWord = '0;
		expName = "reset release";
		while (!done) begin
			checkWord(expName, expWord, ctrl);
			// Seen on ctrl after the next rising edge
			expWord = refWord(refState, refOp);
			expName = $sformatf("line %0d %s",
				(refState == FETCH1) ? nextLine + 1 : nextLine, refState.name());
			driveMemory();
			stepModel();
			cycles++;
			if (refState == HALT) begin
				haltCycles++;
			end
			if ((errCount != 0) || (haltCycles > 10)) begin
				done = 1'b1;
			end else if (cycles >= cycleLimit) begin
				$display("Timeout: the unit did not reach halt within %0d cycles", cycleLimit);
				timeouts++;
				done = 1'b1;
			end else begin
				@(negedge clk);
			end
		end

		assertFails = i_controlUnit.i_cuProps.failCount;
		$display("Errors: %0d, assertion failures: %0d, timeouts: %0d",
			errCount, assertFails, timeouts);
		if ((errCount == 0) && (assertFails == 0) && (timeouts == 0)) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
design/cuPkg.sv
design/insDecoder.sv
design/microSequencer.sv
design/controlWordGen.sv
design/controlUnit.sv
verif/cu_props.sv
verif/cu_tb.sv

/* Makefile */
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
TOP ?= cu_tb
FILELIST ?= tb.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJDIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJDIR)

/* verif/cu_stim.txt */
// opcode(hex) ackDelay(cycles) z1 z2
// z1 and z2 are presented with the fetch acknowledge only
00 0 0 0
22 3 0 1
2F 1 1 0
4D 0 0 0
40 2 0 0
6B 5 1 1
8D 2 0 0
8C 0 1 0
8B 4 0 1
82 1 0 0
A0 0 0 0
A1 1 0 0
A2 0 1 1
A3 3 0 0
A4 0 0 0
A5 1 0 0
C0 1 0 0
C1 0 1 0
C1 2 0 1
C2 0 0 0
C2 1 1 1
32 0 0 0
E0 1 0 0
01 2 0 0
